/* hdl/tft_pkg.sv */
package tft_pkg;

	// Memory word and pixel width
	localparam int DATA_W = 16;

	// Sync, back porch, display, front porch
	localparam int PORCH_N = 4;

	typedef enum logic [1:0] {
		PH_SYNC  = 2'd0,
		PH_BACK  = 2'd1,
		PH_DISP  = 2'd2,
		PH_FRONT = 2'd3
	} phase_e;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// Raw word on the memory side, color fields on the video side
	typedef union packed {
		logic [DATA_W-1:0] raw;
		rgb565_t           color;
	} pixel_word_u;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb888_t;

	// Value of the bus we line
	typedef enum logic {
		BUS_RD = 1'b0,
		BUS_WR = 1'b1
	} bus_cmd_e;

endpackage

/* hdl/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if #(
	parameter int ADDR_W = 8
);

	logic req;
	logic we;
	logic [ADDR_W-1:0] addr;
	tft_pkg::pixel_word_u wdata;
	logic ack;
	tft_pkg::pixel_word_u rdata;
	logic rvalid;

	modport requester (output req, we, addr, wdata, input ack, rdata, rvalid);

	modport arbiter (input req, we, addr, wdata, output ack, rdata, rvalid);

endinterface

/* hdl/tft_timing.sv */
`timescale 1ns/1ps

module tft_timing #(
	parameter int HT [tft_pkg::PORCH_N] = '{2, 3, 8, 2},
	parameter int VT [tft_pkg::PORCH_N] = '{1, 1, 4, 1}
) (
	input  logic clkSYS,
	input  logic aclr,
	input  logic pix_stb,
	output logic hsync,
	output logic vsync,
	output logic active,
	output logic vblank,
	output logic frame_start
);

	localparam int CNT_W = 16;

	tft_pkg::phase_e hphase, hnext;
	tft_pkg::phase_e vphase, vnext;
	logic [CNT_W-1:0] hcnt, vcnt;
	logic line_end;

	assign hnext = tft_pkg::phase_e'(hphase + 2'd1);
	assign vnext = tft_pkg::phase_e'(vphase + 2'd1);

	// Front porch expiry closes the line
	assign line_end = pix_stb && hcnt == '0 && hphase == tft_pkg::PH_FRONT;

	// Start in front porch so the first strobe enters sync
	always_ff @(posedge clkSYS, posedge aclr)
		if (aclr) begin
			hphase <= tft_pkg::PH_FRONT;
			hcnt <= '0;
		end else if (pix_stb) begin
			if (hcnt == '0) begin
				hphase <= hnext;
				hcnt <= CNT_W'(HT[hnext] - 1);
			end else
				hcnt <= hcnt - 1'b1;
		end

	always_ff @(posedge clkSYS, posedge aclr)
		if (aclr) begin
			vphase <= tft_pkg::PH_FRONT;
			vcnt <= '0;
		end else if (line_end) begin
			if (vcnt == '0) begin
				vphase <= vnext;
				vcnt <= CNT_W'(VT[vnext] - 1);
			end else
				vcnt <= vcnt - 1'b1;
		end

	always_ff @(posedge clkSYS, posedge aclr)
		if (aclr)
			frame_start <= 1'b0;
		else
			frame_start <= line_end && vcnt == '0 && vphase == tft_pkg::PH_FRONT;

	// Syncs are active low
	assign hsync = hphase != tft_pkg::PH_SYNC;
	assign vsync = vphase != tft_pkg::PH_SYNC;
	assign vblank = vphase != tft_pkg::PH_DISP;
	assign active = hphase == tft_pkg::PH_DISP && !vblank;

endmodule

/* hdl/pixel_fifo.sv */
`timescale 1ns/1ps

module pixel_fifo #(
	parameter int DEPTH = 16
) (
	input  logic clkSYS,
	input  logic aclr,
	input  logic flush,
	input  logic wr,
	input  tft_pkg::pixel_word_u wdata,
	input  logic rd,
	output tft_pkg::pixel_word_u rdata,
	output logic empty
);

	localparam int PW = $clog2(DEPTH);

	tft_pkg::pixel_word_u mem [DEPTH];
	logic [PW:0] wr_ptr, rd_ptr, count;
	logic full;

	assign count = wr_ptr - rd_ptr;
	assign full = count == (PW + 1)'(DEPTH);
	assign empty = count == '0;

	// Head word is visible without a read
	assign rdata = mem[rd_ptr[PW-1:0]];

	always_ff @(posedge clkSYS)
		if (wr && !full && !flush)
			mem[wr_ptr[PW-1:0]] <= wdata;

	always_ff @(posedge clkSYS, posedge aclr)
		if (aclr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end

endmodule

/* hdl/tft_scanout.sv */
`timescale 1ns/1ps

module tft_scanout #(
	parameter int ADDR_W = 8,
	parameter int BURST = 4,
	parameter int BASE = 16,
	parameter int FIFO_DEPTH = 16
) (
	input  logic clkSYS,
	input  logic aclr,
	input  logic pix_stb,
	input  logic active,
	input  logic vblank,
	mem_bus_if.requester bus,
	output logic fifo_wr,
	output tft_pkg::pixel_word_u fifo_wdata,
	output logic fifo_rd,
	input  tft_pkg::pixel_word_u fifo_rdata,
	input  logic fifo_empty,
	output logic fifo_flush,
	output logic de,
	output tft_pkg::rgb888_t rgb,
	output logic underrun
);

	localparam int CR_W = $clog2(FIFO_DEPTH) + 1;

	logic [CR_W-1:0] credit;
	logic [ADDR_W-1:0] addr;
	logic req;
	logic room;
	tft_pkg::rgb888_t pix;

	// Words requested but not yet read out
	assign room = (FIFO_DEPTH - int'(credit)) >= BURST;

	assign bus.req = req;
	assign bus.we = tft_pkg::BUS_RD;
	assign bus.addr = addr;
	assign bus.wdata = '0;

	always_ff @(posedge clkSYS, posedge aclr)
		if (aclr)
			req <= 1'b0;
		else if (req) begin
			if (bus.ack)
				req <= 1'b0;
		end else if (room && !vblank)
			req <= 1'b1;

	always_ff @(posedge clkSYS, posedge aclr)
		if (aclr) begin
			credit <= '0;
			addr <= ADDR_W'(BASE);
		end else if (vblank) begin
			credit <= '0;
			addr <= ADDR_W'(BASE);
		end else begin
			credit <= credit + (bus.ack ? CR_W'(BURST) : '0) - (fifo_rd ? 1'b1 : 1'b0);
			if (bus.ack)
				addr <= addr + ADDR_W'(BURST);
		end

	assign fifo_wr = bus.rvalid;
	assign fifo_wdata = bus.rdata;
	assign fifo_flush = vblank;
	assign fifo_rd = pix_stb && active && !fifo_empty;

	// Zero fill below the 565 fields
	assign pix.r = {fifo_rdata.color.r, 3'b000};
	assign pix.g = {fifo_rdata.color.g, 2'b00};
	assign pix.b = {fifo_rdata.color.b, 3'b000};

	always_ff @(posedge clkSYS, posedge aclr)
		if (aclr) begin
			de <= 1'b0;
			rgb <= '0;
			underrun <= 1'b0;
		end else if (pix_stb) begin
			de <= active;
			rgb <= fifo_rd ? pix : '0;
			if (active && fifo_empty)
				underrun <= 1'b1;
		end

endmodule

/* hdl/fill_engine.sv */
`timescale 1ns/1ps

module fill_engine #(
	parameter int ADDR_W = 8
) (
	input  logic clkSYS,
	input  logic aclr,
	input  logic fill_stb,
	input  logic [ADDR_W-1:0] fill_addr,
	input  logic [ADDR_W-1:0] fill_len,
	input  logic [tft_pkg::DATA_W-1:0] fill_color,
	mem_bus_if.requester bus,
	output logic fill_done
);

	logic busy;
	logic [ADDR_W-1:0] addr;
	logic [ADDR_W-1:0] left;
	tft_pkg::pixel_word_u word;

	assign bus.req = busy;
	assign bus.we = tft_pkg::BUS_WR;
	assign bus.addr = addr;
	assign bus.wdata = word;

	// Strobes while busy are dropped
	always_ff @(posedge clkSYS, posedge aclr)
		if (aclr) begin
			busy <= 1'b0;
			left <= '0;
			fill_done <= 1'b0;
		end else begin
			fill_done <= 1'b0;
			if (!busy) begin
				if (fill_stb) begin
					busy <= fill_len != '0;
					left <= fill_len;
					fill_done <= fill_len == '0;
				end
			end else if (bus.ack) begin
				left <= left - 1'b1;
				if (left == ADDR_W'(1)) begin
					busy <= 1'b0;
					fill_done <= 1'b1;
				end
			end
		end

	always_ff @(posedge clkSYS)
		if (!busy && fill_stb) begin
			addr <= fill_addr;
			word.raw <= fill_color;
		end else if (busy && bus.ack)
			addr <= addr + 1'b1;

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter #(
	parameter int ADDR_W = 8,
	parameter int BURST = 4
) (
	input  logic clkSYS,
	input  logic aclr,
	mem_bus_if.arbiter scan,
	mem_bus_if.arbiter fill,
	output logic ram_en,
	output logic ram_we,
	output logic [ADDR_W-1:0] ram_addr,
	output logic [tft_pkg::DATA_W-1:0] ram_wdata,
	input  logic [tft_pkg::DATA_W-1:0] ram_rdata
);

	localparam int RD_LAT = 2;
	localparam int SEQ_W = $clog2(BURST + RD_LAT + 1);

	logic [SEQ_W-1:0] seq;
	logic [ADDR_W-1:0] burst_addr;
	logic [1:0] rd_pipe;
	logic rd_owner;
	logic busy, issue, grant_scan, grant_fill, rd_start;
	tft_pkg::pixel_word_u rd_word;

	// Held until the last rvalid of a burst
	assign busy = seq != '0;
	assign issue = seq > SEQ_W'(RD_LAT);

	// Scan-out has fixed priority
	assign grant_scan = !busy && scan.req;
	assign grant_fill = !busy && !scan.req && fill.req;
	assign rd_start = (grant_scan && scan.we == tft_pkg::BUS_RD) ||
		(grant_fill && fill.we == tft_pkg::BUS_RD);

	assign scan.ack = grant_scan;
	assign fill.ack = grant_fill;

	assign ram_en = grant_scan || grant_fill || issue;
	assign ram_we = grant_scan ? scan.we : (grant_fill ? fill.we : 1'b0);
	assign ram_addr = issue ? burst_addr : (grant_scan ? scan.addr : fill.addr);
	assign ram_wdata = grant_scan ? scan.wdata.raw : fill.wdata.raw;

	assign rd_word.raw = ram_rdata;
	assign scan.rdata = rd_word;
	assign fill.rdata = rd_word;
	assign scan.rvalid = rd_pipe[1] && !rd_owner;
	assign fill.rvalid = rd_pipe[1] && rd_owner;

	always_ff @(posedge clkSYS, posedge aclr)
		if (aclr) begin
			seq <= '0;
			rd_pipe <= '0;
			rd_owner <= 1'b0;
		end else begin
			rd_pipe <= {rd_pipe[0], rd_start || issue};
			if (rd_start) begin
				seq <= SEQ_W'(BURST + RD_LAT - 1);
				rd_owner <= grant_fill;
			end else if (busy)
				seq <= seq - 1'b1;
		end

	always_ff @(posedge clkSYS)
		if (rd_start)
			burst_addr <= ram_addr + 1'b1;
		else if (issue)
			burst_addr <= burst_addr + 1'b1;

endmodule

/* hdl/video_ram.sv */
`timescale 1ns/1ps

module video_ram #(
	parameter int ADDR_W = 8
) (
	input  logic clkSYS,
	input  logic ram_en,
	input  logic ram_we,
	input  logic [ADDR_W-1:0] ram_addr,
	input  logic [tft_pkg::DATA_W-1:0] ram_wdata,
	output logic [tft_pkg::DATA_W-1:0] ram_rdata
);

	logic [tft_pkg::DATA_W-1:0] mem [2**ADDR_W];
	logic [tft_pkg::DATA_W-1:0] rd_q;

	always_ff @(posedge clkSYS)
		if (ram_en && ram_we)
			mem[ram_addr] <= ram_wdata;

	// Array read, then output register
	always_ff @(posedge clkSYS) begin
		if (ram_en && !ram_we)
			rd_q <= mem[ram_addr];
		ram_rdata <= rd_q;
	end

endmodule

/* hdl/tft_subsystem.sv */
`timescale 1ns/1ps

module tft_subsystem #(
	parameter int ADDR_W = 8,
	parameter int BURST = 4,
	parameter int BASE = 16,
	parameter int HT [tft_pkg::PORCH_N] = '{2, 3, 8, 2},
	parameter int VT [tft_pkg::PORCH_N] = '{1, 1, 4, 1},
	parameter int PIX_DIV = 4,
	parameter int FIFO_DEPTH = 16
) (
	input  logic clkSYS,
	input  logic aclr,
	input  logic fill_stb,
	input  logic [ADDR_W-1:0] fill_addr,
	input  logic [ADDR_W-1:0] fill_len,
	input  logic [15:0] fill_color,
	output logic fill_done,
	output logic hsync,
	output logic vsync,
	output logic de,
	output logic dclk,
	output logic [23:0] rgb,
	output logic underrun
);

	localparam int DIV_W = $clog2(PIX_DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic pix_stb, active, vblank;
	logic fifo_wr, fifo_rd, fifo_empty, fifo_flush;
	tft_pkg::pixel_word_u fifo_wdata, fifo_rdata;
	tft_pkg::rgb888_t pix_rgb;
	logic ram_en, ram_we;
	logic [ADDR_W-1:0] ram_addr;
	logic [tft_pkg::DATA_W-1:0] ram_wdata, ram_rdata;

	mem_bus_if #(.ADDR_W(ADDR_W)) scan_bus ();
	mem_bus_if #(.ADDR_W(ADDR_W)) fill_bus ();

	// One pixel every PIX_DIV clocks
	assign pix_stb = div_cnt == DIV_W'(PIX_DIV - 1);

	always_ff @(posedge clkSYS, posedge aclr)
		if (aclr) begin
			div_cnt <= '0;
			dclk <= 1'b0;
		end else begin
			dclk <= pix_stb;
			div_cnt <= pix_stb ? '0 : div_cnt + 1'b1;
		end

	assign rgb = pix_rgb;

	tft_timing #(.HT(HT), .VT(VT)) tft_timing_inst (
		.clkSYS(clkSYS), .aclr(aclr), .pix_stb(pix_stb),
		.hsync(hsync), .vsync(vsync), .active(active), .vblank(vblank),
		.frame_start()
	);

	tft_scanout #(
		.ADDR_W(ADDR_W), .BURST(BURST), .BASE(BASE), .FIFO_DEPTH(FIFO_DEPTH)
	) tft_scanout_inst (
		.clkSYS(clkSYS), .aclr(aclr), .pix_stb(pix_stb), .active(active),
		.vblank(vblank), .bus(scan_bus.requester),
		.fifo_wr(fifo_wr), .fifo_wdata(fifo_wdata), .fifo_rd(fifo_rd),
		.fifo_rdata(fifo_rdata), .fifo_empty(fifo_empty), .fifo_flush(fifo_flush),
		.de(de), .rgb(pix_rgb), .underrun(underrun)
	);

	pixel_fifo #(.DEPTH(FIFO_DEPTH)) pixel_fifo_inst (
		.clkSYS(clkSYS), .aclr(aclr), .flush(fifo_flush),
		.wr(fifo_wr), .wdata(fifo_wdata), .rd(fifo_rd), .rdata(fifo_rdata),
		.empty(fifo_empty)
	);

	fill_engine #(.ADDR_W(ADDR_W)) fill_engine_inst (
		.clkSYS(clkSYS), .aclr(aclr), .fill_stb(fill_stb), .fill_addr(fill_addr),
		.fill_len(fill_len), .fill_color(fill_color), .bus(fill_bus.requester),
		.fill_done(fill_done)
	);

	mem_arbiter #(.ADDR_W(ADDR_W), .BURST(BURST)) mem_arbiter_inst (
		.clkSYS(clkSYS), .aclr(aclr), .scan(scan_bus.arbiter), .fill(fill_bus.arbiter),
		.ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
	);

	video_ram #(.ADDR_W(ADDR_W)) video_ram_inst (
		.clkSYS(clkSYS), .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
	);

endmodule

/* verification/tft_tb_tasks.svh */
`ifndef TFT_TB_TASKS_SVH
`define TFT_TB_TASKS_SVH

localparam int SIG_HSYNC = 0;
localparam int SIG_VSYNC = 1;
localparam int SIG_DE = 2;
localparam int SIG_DCLK = 3;
localparam int SIG_FILL_DONE = 4;

// Frame words as the fill commands left them
logic [15:0] frame_model [2**ADDR_W];

// 565 fields moved to the top bits, zeros below
function automatic tft_pkg::rgb888_t expand565(input logic [15:0] c);
	tft_pkg::rgb888_t p;
	p.r = {c[15:11], 3'b000};
	p.g = {c[10:5], 2'b00};
	p.b = {c[4:0], 3'b000};
	return p;
endfunction

// Random color that no frame word holds yet
function automatic logic [15:0] fresh_color();
	logic [15:0] c;
	bit clash;
	c = 16'($urandom);
	for (int n = 0; n <= FRAME_WORDS; n++) begin
		clash = 0;
		for (int i = 0; i < FRAME_WORDS; i++)
			if (frame_model[BASE + i] === c)
				clash = 1;
		if (clash)
			c = c + 16'd1;
	end
	return c;
endfunction

function automatic logic probe(input int sig);
	case (sig)
		SIG_HSYNC: return hsync;
		SIG_VSYNC: return vsync;
		SIG_DE: return de;
		SIG_DCLK: return dclk;
		default: return fill_done;
	endcase
endfunction

task automatic check_rgb(input string name, input tft_pkg::rgb888_t got,
		input tft_pkg::rgb888_t exp);
	if (got !== exp) begin
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		abort_run();
	end
endtask

// Clocks until the signal moves to the given level
task automatic wait_edge(input int sig, input logic level, input int limit,
		input string what, output int clks);
	logic prev;
	bit seen;
	clks = 0;
	seen = 0;
	while (!seen) begin
		prev = probe(sig);
		step();
		clks++;
		seen = prev !== level && probe(sig) === level;
		if (!seen && clks >= limit) begin
			$display("Timeout after %0d clocks: %s", clks, what);
			abort_run();
		end
	end
endtask

task automatic run_fill(input int addr, input int len, input logic [15:0] color);
	int clks;
	for (int i = 0; i < len; i++)
		frame_model[(addr + i) % (2**ADDR_W)] = color;
	fill_addr = ADDR_W'(addr);
	fill_len = ADDR_W'(len);
	fill_color = color;
	fill_stb = 1'b1;
	step();
	fill_stb = 1'b0;
	wait_edge(SIG_FILL_DONE, 1'b1, 2 * FRAME_CLKS, "fill_done never arrived", clks);
	// Done lasts a single clock
	step();
	check_bit("fill_done", fill_done, 1'b0);
endtask

// One frame from vsync fall to vsync fall, with line and sync counts
task automatic scan_frame();
	int clks;
	int lines;
	int vs_low;
	int disp_lines;
	int line_pix;
	logic prev_h;
	logic prev_v;
	bit done;
	wait_edge(SIG_VSYNC, 1'b0, 2 * FRAME_CLKS, "vsync did not fall", clks);
	frame_pix.delete();
	lines = 0;
	vs_low = 0;
	disp_lines = 0;
	line_pix = 0;
	clks = 0;
	done = 0;
	while (!done) begin
		if (!vsync)
			vs_low++;
		if (dclk && de) begin
			frame_pix.push_back(tft_pkg::rgb888_t'(rgb));
			line_pix++;
		end
		prev_h = hsync;
		prev_v = vsync;
		step();
		clks++;
		if (prev_h && !hsync) begin
			lines++;
			if (line_pix != 0) begin
				check_count("de pixels per line", line_pix, HT[2]);
				disp_lines++;
			end
			line_pix = 0;
		end
		done = prev_v && !vsync;
		if (!done && clks >= 2 * FRAME_CLKS) begin
			$display("Timeout after %0d clocks: frame never ended", clks);
			abort_run();
		end
	end
	check_count("lines per frame", lines, FRAME_LINES);
	check_count("vsync low clocks", vs_low, VT[0] * LINE_CLKS);
	check_count("display lines", disp_lines, VT[2]);
	check_count("de pixels per frame", frame_pix.size(), FRAME_WORDS);
endtask

task automatic verify_frame();
	for (int i = 0; i < FRAME_WORDS; i++)
		check_rgb($sformatf("rgb[%0d]", i), frame_pix[i], expand565(frame_model[BASE + i]));
endtask

`endif

/* verification/tft_subsystem_tb.sv */
`timescale 1ns/1ps

module tft_subsystem_tb;

	localparam int ADDR_W = 8;
	localparam int BURST = 4;
	localparam int BASE = 16;
	localparam int HT [tft_pkg::PORCH_N] = '{2, 3, 8, 2};
	localparam int VT [tft_pkg::PORCH_N] = '{1, 1, 4, 1};
	localparam int PIX_DIV = 4;
	localparam int LINE_CLKS = (HT[0] + HT[1] + HT[2] + HT[3]) * PIX_DIV;
	localparam int FRAME_LINES = VT[0] + VT[1] + VT[2] + VT[3];
	localparam int FRAME_CLKS = FRAME_LINES * LINE_CLKS;
	localparam int FRAME_WORDS = HT[2] * VT[2];

	logic clkSYS;
	logic aclr;
	logic fill_stb;
	logic [ADDR_W-1:0] fill_addr;
	logic [ADDR_W-1:0] fill_len;
	logic [15:0] fill_color;
	logic fill_done;
	logic hsync;
	logic vsync;
	logic de;
	logic dclk;
	logic [23:0] rgb;
	logic underrun;

	// Pixels of the last captured frame, in scan order
	tft_pkg::rgb888_t frame_pix [$];

	tft_subsystem #(
		.ADDR_W(ADDR_W), .BURST(BURST), .BASE(BASE), .HT(HT), .VT(VT),
		.PIX_DIV(PIX_DIV), .FIFO_DEPTH(16)
	) tft_subsystem_inst (
		.clkSYS(clkSYS), .aclr(aclr), .fill_stb(fill_stb), .fill_addr(fill_addr),
		.fill_len(fill_len), .fill_color(fill_color), .fill_done(fill_done),
		.hsync(hsync), .vsync(vsync), .de(de), .dclk(dclk), .rgb(rgb),
		.underrun(underrun)
	);

	always #5 clkSYS = ~clkSYS;

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Inputs change and outputs are read 1 ns after the edge
	task automatic step();
		@(posedge clkSYS);
		#1;
	endtask

	`include "tft_tb_tasks.svh"

	task automatic test_reset();
		int clks;
		check_bit("hsync", hsync, 1'b1);
		check_bit("vsync", vsync, 1'b1);
		check_bit("de", de, 1'b0);
		check_bit("dclk", dclk, 1'b0);
		check_bit("fill_done", fill_done, 1'b0);
		check_bit("underrun", underrun, 1'b0);
		check_rgb("rgb", tft_pkg::rgb888_t'(rgb), '0);
		aclr = 1'b0;
		wait_edge(SIG_DCLK, 1'b1, 4 * PIX_DIV, "dclk did not pulse after reset", clks);
		check_count("clocks to first dclk", clks, PIX_DIV);
		step();
		check_bit("dclk", dclk, 1'b0);
	endtask

	task automatic test_hsync();
		int clks;
		int low_clks;
		wait_edge(SIG_HSYNC, 1'b0, 2 * LINE_CLKS, "hsync did not fall", clks);
		wait_edge(SIG_HSYNC, 1'b1, 2 * LINE_CLKS, "hsync did not rise", low_clks);
		check_count("hsync low clocks", low_clks, HT[0] * PIX_DIV);
		wait_edge(SIG_HSYNC, 1'b0, 2 * LINE_CLKS, "hsync did not fall", clks);
		check_count("hsync period clocks", low_clks + clks, LINE_CLKS);
	endtask

	task automatic test_vsync();
		scan_frame();
		check_bit("underrun", underrun, 1'b0);
	endtask

	task automatic test_full_fill();
		run_fill(BASE, FRAME_WORDS, fresh_color());
		scan_frame();
		verify_frame();
	endtask

	task automatic test_segment_fills();
		for (int s = 0; s < 4; s++)
			run_fill(BASE + 8 * s, 8, fresh_color());
		scan_frame();
		verify_frame();
	endtask

	// Fill lands while the display lines are being fetched
	task automatic test_concurrent_fill();
		int clks;
		wait_edge(SIG_VSYNC, 1'b0, 2 * FRAME_CLKS, "vsync did not fall", clks);
		wait_edge(SIG_DE, 1'b1, 2 * FRAME_CLKS, "de did not rise", clks);
		run_fill(BASE + 4, 16, fresh_color());
		check_bit("underrun", underrun, 1'b0);
		scan_frame();
		verify_frame();
		check_bit("underrun", underrun, 1'b0);
	endtask

	initial begin
		clkSYS = 1'b0;
		aclr = 1'b1;
		fill_stb = 1'b0;
		fill_addr = '0;
		fill_len = '0;
		fill_color = '0;
		void'($urandom(41));
		repeat (3)
			step();
		test_reset();
		test_hsync();
		test_vsync();
		test_full_fill();
		test_segment_fills();
		test_concurrent_fill();
		$display("All tests passed");
		$finish;
	end

endmodule

/* tft_subsystem.f */
+incdir+verification
hdl/tft_pkg.sv
hdl/mem_bus_if.sv
hdl/tft_timing.sv
hdl/pixel_fifo.sv
hdl/tft_scanout.sv
hdl/fill_engine.sv
hdl/mem_arbiter.sv
hdl/video_ram.sv
hdl/tft_subsystem.sv
verification/tft_subsystem_tb.sv

/* Bender.yml */
package:
  name: tft_subsystem

sources:
  - files:
      - hdl/tft_pkg.sv
      - hdl/mem_bus_if.sv
      - hdl/tft_timing.sv
      - hdl/pixel_fifo.sv
      - hdl/tft_scanout.sv
      - hdl/fill_engine.sv
      - hdl/mem_arbiter.sv
      - hdl/video_ram.sv
      - hdl/tft_subsystem.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tft_subsystem_tb.sv
